//--- Makefile
# Verilator build and run of the zmips testbench
# The run target fails when the testbench ends in $fatal

SIM := obj_dir/Vzmips_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module zmips_tb -f tb.f

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

//--- tb.f
+incdir+verilog
verilog/zmips_pkg.sv
verilog/zmips_pipe_if.sv
verilog/zmips_regfile.sv
verilog/zmips_alu.sv
verilog/zmips_fetch.sv
verilog/zmips_decode.sv
verilog/zmips_execute.sv
verilog/zmips_mem_wb.sv
verilog/zmips_hazard_unit.sv
verilog/zmips_top.sv
verif/zmips_tb.sv

//--- verif/zmips_tb.sv
// Testbench of the zmips core with clock, memory models, instruction encoders and directed tests
// Each test builds a program, runs it to its final self-branch and checks the logged stores
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_tb_clock
(
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end
endmodule

module zmips_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_CYCLES  = 200;  // Budget per test
    localparam int DRAIN_CYCLES = 20;   // Lets the last stores leave the pipe

    // Funct bits 5:3
    localparam logic [2:0] OP_ADD = 3'b000;
    localparam logic [2:0] OP_SUB = 3'b001;
    localparam logic [2:0] OP_AND = 3'b010;
    localparam logic [2:0] OP_OR  = 3'b011;
    localparam logic [2:0] OP_XOR = 3'b100;
    // Shift select in funct bits 4:3
    localparam logic [1:0] SH_SLL  = 2'b00;
    localparam logic [1:0] SH_SRL  = 2'b01;
    localparam logic [1:0] SH_SRA  = 2'b10;
    localparam logic [1:0] SH_PASS = 2'b11;
    // Branch flag select in bits 27:26
    localparam logic [1:0] BR_Z      = 2'b00;
    localparam logic [1:0] BR_C      = 2'b01;
    localparam logic [1:0] BR_ALWAYS = 2'b11;

    logic        clk;
    logic        rst;
    logic [31:0] i_addr;
    logic [31:0] i_data;
    logic [31:0] d_addr;
    logic [31:0] d_data_i;
    logic [31:0] d_data_o;
    logic        d_rd;
    logic        d_wr;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] log_addr [$];      // Stores seen on the data port in order
    logic [31:0] log_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [7:0]  emit_ptr;          // Next free instruction slot

    zmips_tb_clock u_clock (.clk(clk));

    zmips_top dut
    (
        .clk      (clk),
        .rst      (rst),
        .i_data   (i_data),
        .i_addr   (i_addr),
        .d_data_i (d_data_i),
        .d_addr   (d_addr),
        .d_data_o (d_data_o),
        .d_rd     (d_rd),
        .d_wr     (d_wr)
    );

    // Both memories answer in the same cycle
    assign i_data   = imem[i_addr[9:2]];
    assign d_data_i = d_rd ? dmem[d_addr[9:2]] : ~dmem[d_addr[9:2]];   // Garbled without d_rd

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return ~addr ^ (addr * 32'h9e37_79b9);
    endfunction

    // Data memory refills during reset, then writes and logs each store
    always @(posedge clk)
    begin
        if (rst)
        begin
            log_addr.delete();
            log_data.delete();
            for (int i = 0; i < 256; i++)
            begin
                dmem[i] <= fill_word(32'(i) << 2);
            end
        end
        else if (d_wr)
        begin
            dmem[d_addr[9:2]] <= d_data_o;
            log_addr.push_back(d_addr);
            log_data.push_back(d_data_o);
        end
    end

    function automatic logic [31:0] reg_instr(input logic mem, input logic wb, input logic shift,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
        input logic [4:0] shamt, input logic [5:0] funct);
        return {`ZMIPS_FMT_REG, mem, wb, 1'b0, shift, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] alu_instr(input logic [2:0] op, input logic [4:0] rd,
        input logic [4:0] rs, input logic [4:0] rt, input logic [2:0] flag_en);
        return reg_instr(1'b0, 1'b1, 1'b0, rs, rt, rd, 5'd0, {op, flag_en});
    endfunction

    function automatic logic [31:0] shift_instr(input logic [1:0] sel, input logic [4:0] rd,
        input logic [4:0] rs, input logic [4:0] shamt);
        return reg_instr(1'b0, 1'b1, 1'b1, rs, 5'd0, rd, shamt, {1'b0, sel, 3'b000});
    endfunction

    function automatic logic [31:0] load_instr(input logic [4:0] rd, input logic [4:0] rs);
        return reg_instr(1'b1, 1'b1, 1'b0, rs, 5'd0, rd, 5'd0, 6'd0);
    endfunction

    function automatic logic [31:0] store_instr(input logic [4:0] rs, input logic [4:0] rt);
        return reg_instr(1'b1, 1'b0, 1'b0, rs, rt, 5'd0, 5'd0, 6'd0);
    endfunction

    function automatic logic [31:0] li_instr(input logic [25:0] imm);
        return {`ZMIPS_FMT_LI, 4'b0000, imm};
    endfunction

    // Offset counts words from the branch address plus 4
    function automatic logic [31:0] branch_instr(input logic on_set, input logic [1:0] sel,
        input logic [25:0] offset);
        return {`ZMIPS_FMT_BR, on_set, 1'b0, sel, offset};
    endfunction

    function automatic logic [31:0] sext26(input logic [25:0] imm);
        return {{6{imm[25]}}, imm};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                         // Drive and sample away from the edge
    endtask

    task automatic emit(input logic [31:0] instr);
        imem[emit_ptr] = instr;
        emit_ptr = emit_ptr + 8'd1;
    endtask

    // Load immediate into r0, then pass it on to rd
    task automatic load_reg(input logic [4:0] rd, input logic [25:0] imm);
        emit(li_instr(imm));
        emit(shift_instr(SH_PASS, rd, 5'd0, 5'd0));
    endtask

    task automatic setup_addr(input logic [25:0] base);
        load_reg(5'd8, base);       // r8 store pointer
        load_reg(5'd9, 26'd4);      // r9 pointer step
    endtask

    // Stores registers first..last at r8, stepping r8 after each
    task automatic store_run(input int first, input int last);
        for (int k = first; k <= last; k++)
        begin
            emit(store_instr(5'd8, 5'(k)));
            emit(alu_instr(OP_ADD, 5'd8, 5'd8, 5'd9, 3'b000));
        end
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Holds reset and clears the program while the memories refill
    task automatic start_program();
        next_cycle();
        rst = 1'b1;
        emit_ptr = 8'd0;
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = 32'd0;        // NOP
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic release_reset();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic compare_log();
        check_value(32'(log_addr.size()), 32'(exp_addr.size()), "number of stores");
        foreach (exp_addr[i])
        begin
            check_value(log_addr[i], exp_addr[i], $sformatf("address of store %0d", i));
            check_value(log_data[i], exp_data[i], $sformatf("data of store %0d", i));
        end
    endtask

    // Closes the program with a branch to itself and runs until it is fetched
    task automatic run_program();
        logic [31:0] end_addr;
        end_addr = {22'd0, emit_ptr, 2'b00};
        emit(branch_instr(1'b1, BR_ALWAYS, 26'h3ff_ffff));
        release_reset();
        while (i_addr !== end_addr)
        begin
            next_cycle();
        end
        repeat (DRAIN_CYCLES) next_cycle();
        compare_log();
    endtask

    task automatic reset_state_test();
        start_program();
        release_reset();
        for (int k = 0; k < 8; k++)
        begin
            check_value(i_addr, 32'(k * 4), "i_addr after reset");
            check_value({30'd0, d_rd, d_wr}, 32'd0, "data strobes after reset");
            next_cycle();
        end
    endtask

    task automatic alu_chain_test();
        logic [25:0] imm_a;
        logic [25:0] imm_b;
        logic [25:0] imm_c;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        logic [31:0] r6;
        imm_a = 26'($urandom);
        imm_b = 26'($urandom);
        imm_c = 26'($urandom);
        start_program();
        setup_addr(26'h80);
        load_reg(5'd10, imm_c);
        load_reg(5'd1, imm_a);
        load_reg(5'd2, imm_b);
        emit(alu_instr(OP_ADD, 5'd3, 5'd1, 5'd2, 3'b000));     // rt from EX/MEM
        emit(alu_instr(OP_SUB, 5'd4, 5'd3, 5'd10, 3'b000));    // rs from EX/MEM
        emit(alu_instr(OP_AND, 5'd5, 5'd4, 5'd3, 3'b000));     // rt from MEM/WB
        emit(alu_instr(OP_OR, 5'd6, 5'd5, 5'd1, 3'b000));
        emit(alu_instr(OP_XOR, 5'd7, 5'd6, 5'd5, 3'b000));
        store_run(3, 7);
        r3 = sext26(imm_a) + sext26(imm_b);
        r4 = r3 - sext26(imm_c);
        r5 = r4 & r3;
        r6 = r5 | sext26(imm_a);
        expect_store(32'h80, r3);
        expect_store(32'h84, r4);
        expect_store(32'h88, r5);
        expect_store(32'h8c, r6);
        expect_store(32'h90, r6 ^ r5);
        run_program();
    endtask

    task automatic shift_test();
        logic [25:0] imm_v;
        logic [4:0]  sh_a;
        logic [4:0]  sh_b;
        logic [4:0]  sh_c;
        logic [31:0] v;
        imm_v = 26'($urandom) | 26'h200_0000;   // Negative once sign extended
        sh_a = 5'($urandom);
        sh_b = 5'($urandom);
        sh_c = 5'($urandom);
        v = sext26(imm_v);
        start_program();
        setup_addr(26'h100);
        load_reg(5'd1, imm_v);
        emit(shift_instr(SH_SLL, 5'd2, 5'd1, sh_a));
        emit(shift_instr(SH_SRL, 5'd3, 5'd1, sh_b));
        emit(shift_instr(SH_SRA, 5'd4, 5'd1, sh_c));
        emit(shift_instr(SH_PASS, 5'd5, 5'd1, sh_a));    // shamt ignored
        store_run(2, 5);
        expect_store(32'h100, v << sh_a);
        expect_store(32'h104, v >> sh_b);
        expect_store(32'h108, (v >> sh_c) | ~(32'hffff_ffff >> sh_c));  // Ones shifted in
        expect_store(32'h10c, v);
        run_program();
    endtask

    task automatic load_use_test();
        logic [25:0] imm_x;
        logic [25:0] imm_y;
        imm_x = 26'($urandom);
        imm_y = 26'($urandom);
        start_program();
        load_reg(5'd8, 26'h200);
        load_reg(5'd1, imm_x);
        load_reg(5'd2, imm_y);
        emit(store_instr(5'd8, 5'd1));
        emit(load_instr(5'd3, 5'd8));
        emit(alu_instr(OP_ADD, 5'd4, 5'd3, 5'd2, 3'b000));     // Stall on rs
        emit(load_instr(5'd5, 5'd8));
        emit(alu_instr(OP_SUB, 5'd6, 5'd2, 5'd5, 3'b000));     // Stall on rt
        emit(store_instr(5'd8, 5'd4));
        emit(store_instr(5'd8, 5'd6));
        expect_store(32'h200, sext26(imm_x));
        expect_store(32'h200, sext26(imm_x) + sext26(imm_y));
        expect_store(32'h200, sext26(imm_y) - sext26(imm_x));
        run_program();
    endtask

    task automatic branch_test();
        logic [25:0] imm_v;
        logic [31:0] v;
        logic        flag_z;
        logic        flag_c;
        imm_v = 26'($urandom);
        v = sext26(imm_v);
        flag_z = (v - v) == 32'd0;
        flag_c = v >= v;                        // No borrow
        start_program();
        setup_addr(26'h300);
        load_reg(5'd11, 26'h111);               // Markers of each store
        load_reg(5'd12, 26'h222);
        load_reg(5'd13, 26'h333);
        load_reg(5'd14, 26'h444);
        load_reg(5'd1, imm_v);
        emit(shift_instr(SH_PASS, 5'd2, 5'd0, 5'd0));       // r2 equals r1
        emit(alu_instr(OP_SUB, 5'd3, 5'd1, 5'd2, 3'b111));  // Updates N, C and Z
        emit(branch_instr(1'b1, BR_Z, 26'd1));              // Flags forwarded from execute
        emit(store_instr(5'd8, 5'd11));
        emit(branch_instr(1'b0, BR_C, 26'd1));              // Flags from the register
        emit(store_instr(5'd8, 5'd12));
        emit(alu_instr(OP_ADD, 5'd8, 5'd8, 5'd9, 3'b000));
        emit(branch_instr(1'b1, BR_ALWAYS, 26'd1));
        emit(store_instr(5'd8, 5'd13));
        emit(store_instr(5'd8, 5'd14));
        if (!flag_z)
        begin
            expect_store(32'h300, 32'h111);
        end
        if (flag_c)
        begin
            expect_store(32'h300, 32'h222);
        end
        expect_store(32'h304, 32'h444);
        run_program();
    endtask

    initial
    begin
        rst = 1'b1;
        emit_ptr = 8'd0;
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = 32'd0;
        end
        void'($urandom(1075));
        reset_state_test();
        alu_chain_test();
        shift_test();
        load_use_test();
        branch_test();
        $display("All tests passed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("Some tests failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- verilog/zmips_alu.sv
// ALU: add, subtract, logic, barrel shift and pass of operand a
// Produces N, C and Z; C is the carry for add, no borrow for sub and 0 otherwise
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_alu
(
    input  zmips_pkg::word_t   a,
    input  zmips_pkg::word_t   b,
    input  zmips_pkg::alu_op_t op,
    input  logic [4:0]         shamt,
    output zmips_pkg::word_t   y,
    output zmips_pkg::flags_t  flags
);

    logic                 sub;
    logic [`ZMIPS_XLEN:0] sum;      // Carry out in the top bit
    logic                 carry;

    // Shared adder, sub adds ~b plus one so the carry reads as no borrow
    assign sub = (op == `ZMIPS_ALU_SUB);
    assign sum = {1'b0, a} + {1'b0, sub ? ~b : b} + {{`ZMIPS_XLEN{1'b0}}, sub};

    always_comb
    begin
        carry = 1'b0;
        case (op)
            `ZMIPS_ALU_ADD, `ZMIPS_ALU_SUB:
            begin
                y     = sum[`ZMIPS_XLEN-1:0];
                carry = sum[`ZMIPS_XLEN];
            end
            `ZMIPS_ALU_AND:  y = a & b;
            `ZMIPS_ALU_OR:   y = a | b;
            `ZMIPS_ALU_XOR:  y = a ^ b;
            `ZMIPS_ALU_SLL:  y = a << shamt;
            `ZMIPS_ALU_SRL:  y = a >> shamt;
            `ZMIPS_ALU_SRA:  y = $signed(a) >>> shamt;   // Sign fill
            `ZMIPS_ALU_PASS: y = a;
            default:         y = '0;                     // Unused funct codes
        endcase
    end

    assign flags = {y[`ZMIPS_XLEN-1], carry, y == '0};  // {N, C, Z}

endmodule

//--- verilog/zmips_config.svh
// Shared constants of the zmips core: word width, format codes, ALU ops and forward selects
// Included by every file that uses one of the macros
`ifndef ZMIPS_CONFIG_SVH
`define ZMIPS_CONFIG_SVH

`define ZMIPS_XLEN      32      // Data and address width
`define ZMIPS_NREGS     32      // General registers
`define ZMIPS_PC_STEP   4       // Bytes per instruction

// Instruction format in bits 31:30, 11 runs as a NOP
`define ZMIPS_FMT_REG   2'b00
`define ZMIPS_FMT_LI    2'b01
`define ZMIPS_FMT_BR    2'b10

// Internal ALU op, {shift, op[2:0]}
`define ZMIPS_ALU_ADD   4'b0000
`define ZMIPS_ALU_SUB   4'b0001
`define ZMIPS_ALU_AND   4'b0010
`define ZMIPS_ALU_OR    4'b0011
`define ZMIPS_ALU_XOR   4'b0100
`define ZMIPS_ALU_SLL   4'b1000
`define ZMIPS_ALU_SRL   4'b1001
`define ZMIPS_ALU_SRA   4'b1010
`define ZMIPS_ALU_PASS  4'b1011 // Operand a straight through

// Execute operand source
`define ZMIPS_FWD_REG   2'b00   // Value read in decode
`define ZMIPS_FWD_WB    2'b01   // Write-back data
`define ZMIPS_FWD_MEM   2'b10   // EX/MEM result

`endif

//--- verilog/zmips_decode.sv
// Decode stage: field split, control decode, branch decision and the ID/EX register
// Branches resolve here, with flags forwarded from the instruction in execute
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_decode
(
    input  logic                clk,
    input  logic                rst,
    input  zmips_pkg::word_t    if_pc_next,
    input  zmips_pkg::word_t    if_ir,
    input  logic                stall,
    input  zmips_pkg::reg_idx_t wb_addr,
    input  zmips_pkg::word_t    wb_data,
    input  logic                wb_wr,
    input  zmips_pkg::flags_t   ex_flags,
    input  zmips_pkg::flags_t   ex_wr_flags,
    input  zmips_pkg::flags_t   flags,
    output logic                branch_taken,
    output zmips_pkg::word_t    branch_target,
    output zmips_pkg::reg_idx_t id_rs,
    output zmips_pkg::reg_idx_t id_rt,
    output logic                id_uses_regs,
    zmips_id_ex_if.decode       id_ex
);
    import zmips_pkg::*;

    logic [1:0] fmt;
    logic       is_reg;
    logic       is_li;
    logic       is_br;
    logic       is_mem;         // Load or store
    logic       is_wb;          // Bit 28, write back or load
    reg_idx_t   rd;
    word_t      immd_se;
    word_t      reg_0;
    word_t      reg_1;
    flags_t     fwd_flags;
    logic       flag_bit;       // Flag picked by bits 27:26
    logic       br_cond;
    alu_op_t    alu_op;
    logic       kill;           // Clears the ID/EX controls

    assign fmt     = if_ir[31:30];
    assign is_reg  = (fmt == `ZMIPS_FMT_REG);
    assign is_li   = (fmt == `ZMIPS_FMT_LI);
    assign is_br   = (fmt == `ZMIPS_FMT_BR);
    assign is_mem  = is_reg & if_ir[29];
    assign is_wb   = if_ir[28];
    assign id_rs   = if_ir[25:21];
    assign id_rt   = if_ir[20:16];
    assign rd      = if_ir[15:11];
    assign immd_se = {{6{if_ir[25]}}, if_ir[25:0]};

    assign id_uses_regs = is_reg;   // Only register format reads rs and rt

    zmips_regfile u_regfile
    (
        .clk       (clk),
        .rd_addr_0 (id_rs),
        .rd_addr_1 (id_rt),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .wr        (wb_wr),
        .rd_data_0 (reg_0),
        .rd_data_1 (reg_1)
    );

    // A flag being written by the instruction in execute wins over the register
    assign fwd_flags = (ex_wr_flags & ex_flags) | (~ex_wr_flags & flags);

    always_comb
    begin
        case (if_ir[27:26])
            2'b00:   flag_bit = fwd_flags[0];  // Z
            2'b01:   flag_bit = fwd_flags[1];  // C
            default: flag_bit = fwd_flags[2];  // N, unused for always
        endcase
    end

    // Bit 29 picks branch on set or on clear
    assign br_cond = (&if_ir[27:26]) | (flag_bit == if_ir[29]);

    // Every branch redirects fetch; not taken goes back to the fall-through word
    assign branch_taken  = is_br;
    assign branch_target = br_cond ? if_pc_next + {immd_se[29:0], 2'b00} : if_pc_next;

    // Memory ops and load immediate pass operand a through
    assign alu_op = (is_li || is_mem) ? `ZMIPS_ALU_PASS :
                    if_ir[26] ? {2'b10, if_ir[4:3]} : {1'b0, if_ir[5:3]};

    assign kill = stall | ~(is_reg | is_li);   // Bubble, branch or format 11

    always_ff @(posedge clk)
    begin
        id_ex.reg_0   <= reg_0;
        id_ex.reg_1   <= reg_1;
        id_ex.rs      <= id_rs;
        id_ex.rt      <= id_rt;
        id_ex.wb_reg  <= is_li ? '0 : rd;   // Load immediate targets r0
        id_ex.immd_se <= immd_se;
        id_ex.alu_op  <= alu_op;
        id_ex.shamt   <= if_ir[10:6];
        id_ex.alusrc  <= is_li;
        if (rst || kill)
        begin
            id_ex.memrd    <= 1'b0;
            id_ex.memwr    <= 1'b0;
            id_ex.wrreg    <= 1'b0;
            id_ex.wr_flags <= '0;
        end
        else
        begin
            id_ex.memrd    <= is_mem & is_wb;
            id_ex.memwr    <= is_mem & ~is_wb;
            id_ex.wrreg    <= (is_reg & is_wb) | is_li;
            id_ex.wr_flags <= (is_reg & ~is_mem) ? if_ir[2:0] : '0;  // Memory ops keep flags
        end
    end

endmodule

//--- verilog/zmips_execute.sv
// Execute stage: operand forwarding, ALU, flag registers and the EX/MEM register
// Flags update at the end of execute and are also sent back to decode for branches
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_execute
(
    input  logic                 clk,
    input  logic                 rst,
    zmips_id_ex_if.execute       id_ex,
    input  zmips_pkg::fwd_sel_t  rs_src,
    input  zmips_pkg::fwd_sel_t  rt_src,
    input  zmips_pkg::word_t     wb_data,
    output zmips_pkg::flags_t    flags,
    output zmips_pkg::flags_t    ex_flags,
    output zmips_pkg::flags_t    ex_wr_flags,
    zmips_ex_mem_if.execute      ex_mem
);
    import zmips_pkg::*;

    word_t  a_fwd;      // rs after forwarding
    word_t  b_fwd;      // rt after forwarding, also the store data
    word_t  alu_a;
    word_t  alu_y;

    always_comb
    begin
        case (rs_src)
            `ZMIPS_FWD_WB:  a_fwd = wb_data;
            `ZMIPS_FWD_MEM: a_fwd = ex_mem.alu_rslt;
            default:        a_fwd = id_ex.reg_0;
        endcase
        case (rt_src)
            `ZMIPS_FWD_WB:  b_fwd = wb_data;
            `ZMIPS_FWD_MEM: b_fwd = ex_mem.alu_rslt;
            default:        b_fwd = id_ex.reg_1;
        endcase
    end

    assign alu_a = id_ex.alusrc ? id_ex.immd_se : a_fwd;   // Load immediate

    zmips_alu u_alu
    (
        .a     (alu_a),
        .b     (b_fwd),
        .op    (id_ex.alu_op),
        .shamt (id_ex.shamt),
        .y     (alu_y),
        .flags (ex_flags)
    );

    assign ex_wr_flags = id_ex.wr_flags;

    // Each flag loads only under its own enable
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flags <= '0;
        end
        else
        begin
            flags <= (ex_wr_flags & ex_flags) | (~ex_wr_flags & flags);
        end
    end

    always_ff @(posedge clk)
    begin
        ex_mem.alu_rslt <= alu_y;
        ex_mem.data     <= b_fwd;
        ex_mem.wb_reg   <= id_ex.wb_reg;
        if (rst)
        begin
            ex_mem.memrd <= 1'b0;
            ex_mem.memwr <= 1'b0;
            ex_mem.wrreg <= 1'b0;
        end
        else
        begin
            ex_mem.memrd <= id_ex.memrd;
            ex_mem.memwr <= id_ex.memwr;
            ex_mem.wrreg <= id_ex.wrreg;
        end
    end

endmodule

//--- verilog/zmips_fetch.sv
// Fetch stage: program counter, next-PC choice and the IF/ID register
// A branch in decode redirects the PC and turns the fetched word into a NOP
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_fetch
(
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             branch_taken,   // Branch in decode, redirect
    input  zmips_pkg::word_t branch_target,
    input  zmips_pkg::word_t i_data,
    output zmips_pkg::word_t i_addr,
    output zmips_pkg::word_t if_pc_next,
    output zmips_pkg::word_t if_ir
);
    import zmips_pkg::*;

    word_t pc;
    word_t pc_inc;

    assign pc_inc = pc + `ZMIPS_PC_STEP;
    assign i_addr = pc;     // Instruction memory answers in the same cycle

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc    <= '0;
            if_ir <= '0;    // All zero is a NOP
        end
        else if (!stall)
        begin
            pc    <= branch_taken ? branch_target : pc_inc;
            if_ir <= branch_taken ? '0 : i_data;   // The one bubble after a branch
        end
    end

    // Fall-through address, used as branch base
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            if_pc_next <= pc_inc;
        end
    end

endmodule

//--- verilog/zmips_hazard_unit.sv
// Hazard unit: load-use stall and forward selects for the execute operands
// The EX/MEM match wins over the write-back match
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_hazard_unit
(
    input  zmips_pkg::reg_idx_t  id_rs,
    input  zmips_pkg::reg_idx_t  id_rt,
    input  logic                 id_uses_regs,
    zmips_id_ex_if.hazard        id_ex,
    zmips_ex_mem_if.hazard       ex_mem,
    input  zmips_pkg::reg_idx_t  wb_addr,
    input  logic                 wb_wr,
    output logic                 stall,
    output zmips_pkg::fwd_sel_t  rs_src,
    output zmips_pkg::fwd_sel_t  rt_src
);

    // Load in execute feeding decode; the bubble it inserts ends the stall next cycle
    assign stall = id_ex.memrd & id_uses_regs &
                   ((id_ex.wb_reg == id_rs) | (id_ex.wb_reg == id_rt));

    assign rs_src = (ex_mem.wrreg && ex_mem.wb_reg == id_ex.rs) ? `ZMIPS_FWD_MEM :
                    (wb_wr && wb_addr == id_ex.rs)               ? `ZMIPS_FWD_WB  :
                                                                   `ZMIPS_FWD_REG;

    assign rt_src = (ex_mem.wrreg && ex_mem.wb_reg == id_ex.rt) ? `ZMIPS_FWD_MEM :
                    (wb_wr && wb_addr == id_ex.rt)               ? `ZMIPS_FWD_WB  :
                                                                   `ZMIPS_FWD_REG;

endmodule

//--- verilog/zmips_mem_wb.sv
// Memory and write-back stages: data memory strobes, MEM/WB register, result select
// The write-back bus also feeds the register file and the forwarding muxes
`timescale 1ns/1ps

module zmips_mem_wb
(
    input  logic                clk,
    input  logic                rst,
    zmips_ex_mem_if.mem_wb      ex_mem,
    input  zmips_pkg::word_t    d_data_i,
    output zmips_pkg::word_t    d_addr,
    output zmips_pkg::word_t    d_data_o,
    output logic                d_rd,
    output logic                d_wr,
    output zmips_pkg::reg_idx_t wb_addr,
    output zmips_pkg::word_t    wb_data,
    output logic                wb_wr
);
    import zmips_pkg::*;

    word_t memd;        // Loaded word
    word_t alud;        // ALU result
    logic  memrd;

    // One-cycle strobes straight from EX/MEM
    assign d_addr   = ex_mem.alu_rslt;
    assign d_data_o = ex_mem.data;
    assign d_rd     = ex_mem.memrd;
    assign d_wr     = ex_mem.memwr;

    always_ff @(posedge clk)
    begin
        memd    <= d_data_i;    // Valid in the cycle of d_rd
        alud    <= ex_mem.alu_rslt;
        wb_addr <= ex_mem.wb_reg;
        if (rst)
        begin
            memrd <= 1'b0;
            wb_wr <= 1'b0;
        end
        else
        begin
            memrd <= ex_mem.memrd;
            wb_wr <= ex_mem.wrreg;
        end
    end

    assign wb_data = memrd ? memd : alud;

endmodule

//--- verilog/zmips_pipe_if.sv
// ID/EX and EX/MEM pipeline registers of the zmips core
// Decode and execute drive them, the later stage and the hazard unit read them
`timescale 1ns/1ps

interface zmips_id_ex_if;
    import zmips_pkg::*;

    word_t    reg_0;        // rs value read in decode
    word_t    reg_1;        // rt value
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t wb_reg;       // Destination, r0 for load immediate
    word_t    immd_se;
    alu_op_t  alu_op;
    logic [4:0] shamt;
    logic     alusrc;       // Immediate replaces operand a
    logic     memrd;
    logic     memwr;
    logic     wrreg;
    flags_t   wr_flags;     // Per-flag update enables

    modport decode (output reg_0, reg_1, rs, rt, wb_reg, immd_se, alu_op, shamt,
                    alusrc, memrd, memwr, wrreg, wr_flags);
    modport execute (input reg_0, reg_1, rs, rt, wb_reg, immd_se, alu_op, shamt,
                     alusrc, memrd, memwr, wrreg, wr_flags);
    modport hazard (input rs, rt, wb_reg, memrd);
endinterface

interface zmips_ex_mem_if;
    import zmips_pkg::*;

    word_t    alu_rslt;     // Result, or address of a memory access
    word_t    data;         // Store data
    reg_idx_t wb_reg;
    logic     memrd;
    logic     memwr;
    logic     wrreg;

    modport execute (output alu_rslt, data, wb_reg, memrd, memwr, wrreg);
    modport mem_wb (input alu_rslt, data, wb_reg, memrd, memwr, wrreg);
    modport hazard (input wb_reg, wrreg);
endinterface

//--- verilog/zmips_pkg.sv
// Vector types shared across the zmips core
// Modules import it in their body and use scoped names on their ports
`include "zmips_config.svh"

package zmips_pkg;

    // Data word, address or instruction
    typedef logic [`ZMIPS_XLEN-1:0] word_t;

    // Register number
    typedef logic [$clog2(`ZMIPS_NREGS)-1:0] reg_idx_t;

    typedef logic [3:0] alu_op_t;   // {shift, op}
    typedef logic [1:0] fwd_sel_t;  // One of the ZMIPS_FWD codes

    // Condition flags {N, C, Z}, same order as funct bits 2:0
    typedef logic [2:0] flags_t;

endpackage

//--- verilog/zmips_regfile.sv
// General register file, two read ports and one write port
// A read of the register being written returns the new value
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_regfile
(
    input  logic                clk,
    input  zmips_pkg::reg_idx_t rd_addr_0,
    input  zmips_pkg::reg_idx_t rd_addr_1,
    input  zmips_pkg::reg_idx_t wr_addr,
    input  zmips_pkg::word_t    wr_data,
    input  logic                wr,
    output zmips_pkg::word_t    rd_data_0,
    output zmips_pkg::word_t    rd_data_1
);
    import zmips_pkg::*;

    word_t regs [`ZMIPS_NREGS];

    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through bypass
    assign rd_data_0 = (wr && wr_addr == rd_addr_0) ? wr_data : regs[rd_addr_0];
    assign rd_data_1 = (wr && wr_addr == rd_addr_1) ? wr_data : regs[rd_addr_1];

endmodule

//--- verilog/zmips_top.sv
// Top level of the zmips five-stage core
// Instruction memory is read combinationally at i_addr; data memory is a strobed port
`timescale 1ns/1ps
`include "zmips_config.svh"

module zmips_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`ZMIPS_XLEN-1:0] i_data,
    output logic [`ZMIPS_XLEN-1:0] i_addr,
    input  logic [`ZMIPS_XLEN-1:0] d_data_i,
    output logic [`ZMIPS_XLEN-1:0] d_addr,
    output logic [`ZMIPS_XLEN-1:0] d_data_o,
    output logic                   d_rd,
    output logic                   d_wr
);
    import zmips_pkg::*;

    word_t    if_pc_next;
    word_t    if_ir;
    word_t    branch_target;
    logic     branch_taken;
    logic     stall;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    logic     id_uses_regs;
    flags_t   flags;
    flags_t   ex_flags;
    flags_t   ex_wr_flags;
    fwd_sel_t rs_src;
    fwd_sel_t rt_src;
    reg_idx_t wb_addr;      // Write-back bus
    word_t    wb_data;
    logic     wb_wr;

    zmips_id_ex_if  id_ex ();
    zmips_ex_mem_if ex_mem ();

    zmips_fetch u_fetch (.clk, .rst, .stall, .branch_taken, .branch_target, .i_data,
                         .i_addr, .if_pc_next, .if_ir);

    zmips_decode u_decode (.clk, .rst, .if_pc_next, .if_ir, .stall, .wb_addr, .wb_data,
                           .wb_wr, .ex_flags, .ex_wr_flags, .flags, .branch_taken,
                           .branch_target, .id_rs, .id_rt, .id_uses_regs,
                           .id_ex (id_ex.decode));

    zmips_execute u_execute (.clk, .rst, .id_ex (id_ex.execute), .rs_src, .rt_src,
                             .wb_data, .flags, .ex_flags, .ex_wr_flags,
                             .ex_mem (ex_mem.execute));

    zmips_mem_wb u_mem_wb (.clk, .rst, .ex_mem (ex_mem.mem_wb), .d_data_i, .d_addr,
                           .d_data_o, .d_rd, .d_wr, .wb_addr, .wb_data, .wb_wr);

    zmips_hazard_unit u_hazard (.id_rs, .id_rt, .id_uses_regs, .id_ex (id_ex.hazard),
                                .ex_mem (ex_mem.hazard), .wb_addr, .wb_wr, .stall,
                                .rs_src, .rt_src);

endmodule
